// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = irq_ctrl_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: irq_arbiter.sv
// Fixed-priority interrupt arbiter, registers the winner and pulses the acknowledge to the hart
`timescale 1ns/1ps
`include "irq_macros.svh"

module irq_arbiter
  import irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`IRQ_NUM-1:0] pend_en_i,
  input  irq_cfg_t            cfg_i,
  output irq_ack_t            ack_o
);

  logic [18:0]          prio_vec;
  logic [`IRQ_ID_W-1:0] win_id;
  logic                 mmode_en;
  logic                 umode;
  logic                 take;
  logic                 ack_valid_q;
  logic [`IRQ_ID_W-1:0] ack_id_q;

  // --------------------
  // Priority table
  // --------------------

  // Lines in decreasing priority
  // 31 down to 16, then 11, then 3, then 7
  assign prio_vec = {pend_en_i[31:16], pend_en_i[11], pend_en_i[3], pend_en_i[7]};

  always_comb begin
    win_id = '0;
    casez (prio_vec)
      19'b1???_????_????_????_???: win_id = 5'd31;
      19'b01??_????_????_????_???: win_id = 5'd30;
      19'b001?_????_????_????_???: win_id = 5'd29;
      19'b0001_????_????_????_???: win_id = 5'd28;
      19'b0000_1???_????_????_???: win_id = 5'd27;
      19'b0000_01??_????_????_???: win_id = 5'd26;
      19'b0000_001?_????_????_???: win_id = 5'd25;
      19'b0000_0001_????_????_???: win_id = 5'd24;
      19'b0000_0000_1???_????_???: win_id = 5'd23;
      19'b0000_0000_01??_????_???: win_id = 5'd22;
      19'b0000_0000_001?_????_???: win_id = 5'd21;
      19'b0000_0000_0001_????_???: win_id = 5'd20;
      19'b0000_0000_0000_1???_???: win_id = 5'd19;
      19'b0000_0000_0000_01??_???: win_id = 5'd18;
      19'b0000_0000_0000_001?_???: win_id = 5'd17;
      19'b0000_0000_0000_0001_???: win_id = 5'd16;
      // Machine external
      19'b0000_0000_0000_0000_1??: win_id = 5'd11;
      // Machine software
      19'b0000_0000_0000_0000_01?: win_id = 5'd3;
      // Machine timer is last
      19'b0000_0000_0000_0000_001: win_id = 5'd7;
      default:                     win_id = '0;
    endcase
  end

  // --------------------
  // Take condition
  // --------------------

  // M-mode needs the global enable
  assign mmode_en = (cfg_i.priv == PRIV_LVL_M) && cfg_i.mstatus_mie;
  // U-mode traps on any enabled pending line
  assign umode    = (cfg_i.priv == PRIV_LVL_U);
  assign take     = (|pend_en_i) && (mmode_en || umode);

  // Valid is blocked on the cycle after a pulse
  // A held line re-acks every second cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_valid_q <= 1'b0;
    end else begin
      ack_valid_q <= take && !ack_valid_q;
    end
  end

  // Id only matters while valid is high
  always_ff @(posedge clk_i) begin
    if (take) begin
      ack_id_q <= win_id;
    end
  end

  assign ack_o = '{valid: ack_valid_q, id: ack_id_q};

endmodule

// File: irq_ctrl_props.sv
// Concurrent checks on the controller outputs, bound into the top level alongside the testbench
`timescale 1ns/1ps
`include "irq_macros.svh"

module irq_ctrl_props
  import irq_pkg::*;
(
  input logic                clk_i,
  input logic                rst_ni,
  input logic [`IRQ_NUM-1:0] mip_o,
  input irq_cfg_t            cfg_i,
  input irq_ack_t            ack_o,
  input logic                core_sleep_o
);

  localparam logic [`IRQ_NUM-1:0] VALID = `IRQ_VALID_MASK;

  // --------------------
  // Acknowledge
  // --------------------

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o.valid |=> !ack_o.valid)
    else $error("ack_o.valid high on two consecutive cycles");

  // Winner must be implemented and enabled
  ack_id_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o.valid |-> (VALID[ack_o.id] && cfg_i.mie[ack_o.id]))
    else $error("ack_o.id %0d is reserved or disabled", ack_o.id);

  mip_no_reserved: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_o & ~VALID) == '0)
    else $error("mip_o shows a reserved line");

  // Sleep ends on the edge after an enabled line shows up
  sleep_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_sleep_o && (|(mip_o & cfg_i.mie))) |=> !core_sleep_o)
    else $error("core_sleep_o stayed high with an enabled pending line");

endmodule

bind irq_ctrl_top irq_ctrl_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .mip_o        (mip_o),
  .cfg_i        (cfg_i),
  .ack_o        (ack_o),
  .core_sleep_o (core_sleep_o)
);

// File: irq_ctrl_tb.sv
// Self-checking testbench for the interrupt and sleep controller that the Makefile sim target runs
`timescale 1ns/1ps
`include "irq_macros.svh"

module irq_ctrl_tb
  import irq_pkg::*;
();

  typedef struct packed {
    logic [31:0] irq;
    logic [31:0] mie;
    logic        gie;
    priv_lvl_e   priv;
    logic        exp_ack;
    logic [4:0]  exp_id;
  } row_t;

  localparam int NROWS   = 12;
  localparam int TIMEOUT = 8;

  // --------------------
  // Directed table
  // --------------------

  // Winner order is 31..16, then 11, 3, 7
  row_t rows [NROWS] = '{
    '{32'h0000_0888, 32'hFFFF_FFFF, 1'b1, PRIV_LVL_M, 1'b1, 5'd11},
    '{32'h0000_0088, 32'hFFFF_FFFF, 1'b1, PRIV_LVL_M, 1'b1, 5'd3},
    '{32'h0000_0080, 32'hFFFF_FFFF, 1'b1, PRIV_LVL_M, 1'b1, 5'd7},
    '{32'h0001_0808, 32'hFFFF_FFFF, 1'b1, PRIV_LVL_M, 1'b1, 5'd16},
    '{32'h8000_0008, 32'h0000_0008, 1'b1, PRIV_LVL_M, 1'b1, 5'd3},
    '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1, PRIV_LVL_M, 1'b1, 5'd31},
    // Reserved lines only
    '{32'h0000_0777, 32'hFFFF_FFFF, 1'b1, PRIV_LVL_M, 1'b0, 5'd0},
    // M-mode with global enable clear
    '{32'h0000_0800, 32'hFFFF_FFFF, 1'b0, PRIV_LVL_M, 1'b0, 5'd0},
    '{32'h0000_0800, 32'hFFFF_FFFF, 1'b0, PRIV_LVL_U, 1'b1, 5'd11},
    '{32'h0004_0000, 32'h0000_0000, 1'b1, PRIV_LVL_U, 1'b0, 5'd0},
    '{32'h00C0_0080, 32'h0040_0080, 1'b1, PRIV_LVL_M, 1'b1, 5'd22},
    '{32'h0000_4088, 32'h0000_0080, 1'b1, PRIV_LVL_M, 1'b1, 5'd7}
  };

  logic                clk;
  logic                rst_n;
  logic [`IRQ_NUM-1:0] irq;
  irq_cfg_t            cfg;
  logic                wfi;
  logic                debug_req;
  logic                pipe_idle;
  logic [`IRQ_NUM-1:0] mip;
  irq_ack_t            ack;
  logic                core_sleep;
  logic                wake;
  int                  errors;
  int                  checks;
  int                  seed;

  irq_ctrl_top irq_ctrl_top_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .irq_i        (irq),
    .cfg_i        (cfg),
    .wfi_i        (wfi),
    .debug_req_i  (debug_req),
    .pipe_idle_i  (pipe_idle),
    .mip_o        (mip),
    .ack_o        (ack),
    .core_sleep_o (core_sleep),
    .wake_o       (wake)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reference priority walks lowest first so higher lines overwrite
  function automatic logic [4:0] ref_winner(input logic [31:0] pend);
    logic [4:0] id;
    id = '0;
    if (pend[7]) id = 5'd7;
    if (pend[3]) id = 5'd3;
    if (pend[11]) id = 5'd11;
    for (int k = 16; k < 32; k++) begin
      if (pend[k]) id = k[4:0];
    end
    return id;
  endfunction

  // Edges until core_sleep_o or wake_o is seen at a falling edge
  task automatic count_cycles(input logic on_wake, output int n, output logic found);
    n = 0;
    found = 1'b0;
    while (!found && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      found = on_wake ? wake : core_sleep;
    end
  endtask

  task automatic run_case(input logic [31:0] irq_v, input irq_cfg_t cfg_v,
                          input logic exp_ack, input logic [4:0] exp_id);
    logic got;
    logic prev;
    int   i;
    got = 1'b0;
    i = 0;
    @(posedge clk);
    irq <= irq_v;
    cfg <= cfg_v;
    // Rows with no ack wait out the whole window
    while (!got && i < TIMEOUT) begin
      @(negedge clk);
      got = ack.valid;
      i++;
    end
    checks++;
    if (exp_ack) begin
      assert (got) else begin
        $display("No acknowledge within %0d cycles for irq_i %h", TIMEOUT, irq_v);
        errors++;
      end
    end else begin
      assert (!got) else begin
        $display("MISMATCH ack_o.valid: got %h expected %h", got, exp_ack);
        errors++;
      end
    end
    if (got && exp_ack) begin
      assert (ack.id == exp_id) else begin
        $display("MISMATCH ack_o.id: got %h expected %h", ack.id, exp_id);
        errors++;
      end
    end
    // Reserved lines must be gone
    assert (mip == (irq_v & `IRQ_VALID_MASK)) else begin
      $display("MISMATCH mip_o: got %h expected %h", mip, irq_v & `IRQ_VALID_MASK);
      errors++;
    end
    // Valid never stays high while the line is held
    prev = got;
    repeat (4) begin
      @(negedge clk);
      assert (!(prev && ack.valid)) else begin
        $display("Acknowledge valid stayed high on two consecutive cycles");
        errors++;
      end
      prev = ack.valid;
    end
    @(posedge clk);
    irq <= '0;
    repeat (2) @(posedge clk);
  endtask

  // --------------------
  // Sleep and wake
  // --------------------

  task automatic enter_sleep(input irq_cfg_t cfg_v, input logic expect_sleep, input int busy);
    int   n;
    int   exp_n;
    logic found;
    @(posedge clk);
    cfg <= cfg_v;
    wfi <= 1'b1;
    pipe_idle <= (busy == 0);
    // This edge samples the strobe
    @(posedge clk);
    wfi <= 1'b0;
    // A busy pipe holds the FSM in drain past the timer
    if (busy > 0) begin
      repeat (busy) begin
        @(negedge clk);
        assert (!core_sleep) else begin
          $display("core_sleep_o rose while pipe_idle_i was low");
          errors++;
        end
      end
      @(posedge clk);
      pipe_idle <= 1'b1;
    end
    // Sleep follows two edges after the strobe or one edge after the pipe goes idle
    exp_n = (busy > 0) ? 1 : 2;
    count_cycles(1'b0, n, found);
    checks++;
    if (expect_sleep) begin
      assert (found) else begin
        $display("core_sleep_o did not rise within %0d cycles after WFI", TIMEOUT);
        errors++;
      end
      assert (!found || n == exp_n) else begin
        $display("MISMATCH core_sleep_o latency: got %h expected %h", n, exp_n);
        errors++;
      end
    end else begin
      assert (!found) else begin
        $display("core_sleep_o rose although mstatus_tw refuses WFI in user mode");
        errors++;
      end
    end
  endtask

  task automatic wake_up(input logic use_debug, input int exp_n);
    int   n;
    logic found;
    @(posedge clk);
    if (use_debug) begin
      debug_req <= 1'b1;
    end else begin
      irq <= 32'h0000_0800;
    end
    count_cycles(1'b1, n, found);
    checks++;
    assert (found) else begin
      $display("wake_o did not pulse within %0d cycles", TIMEOUT);
      errors++;
    end
    assert (!found || n == exp_n) else begin
      $display("MISMATCH wake_o latency: got %h expected %h", n, exp_n);
      errors++;
    end
    assert (!core_sleep) else begin
      $display("MISMATCH core_sleep_o: got %h expected %h", core_sleep, 1'b0);
      errors++;
    end
    @(negedge clk);
    assert (!wake) else begin
      $display("wake_o stayed high for more than one cycle");
      errors++;
    end
    @(posedge clk);
    debug_req <= 1'b0;
    irq <= '0;
    repeat (2) @(posedge clk);
  endtask

  initial begin
    irq_cfg_t    c;
    logic [31:0] r_irq;
    logic [31:0] rnd;
    logic [31:0] pend;
    logic        exp;
    seed = 35;
    errors = 0;
    checks = 0;
    rst_n = 1'b0;
    irq = '0;
    cfg = '{mie: '0, mstatus_mie: 1'b0, mstatus_tw: 1'b0, priv: PRIV_LVL_M};
    wfi = 1'b0;
    debug_req = 1'b0;
    pipe_idle = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!ack.valid && !core_sleep && !wake && mip == '0) else begin
      $display("Outputs were not cleared by reset");
      errors++;
    end
    for (int r = 0; r < NROWS; r++) begin
      c = '{mie: rows[r].mie, mstatus_mie: rows[r].gie, mstatus_tw: 1'b0, priv: rows[r].priv};
      run_case(rows[r].irq, c, rows[r].exp_ack, rows[r].exp_id);
    end
    // Random lines with the platform lines quiet in every other case
    for (int k = 0; k < 16; k++) begin
      r_irq = $random(seed);
      if (k[0]) r_irq[31:16] = '0;
      c.mie = $random(seed);
      rnd = $random(seed);
      c.mstatus_mie = rnd[0];
      c.mstatus_tw = 1'b0;
      c.priv = rnd[1] ? PRIV_LVL_M : PRIV_LVL_U;
      pend = r_irq & `IRQ_VALID_MASK & c.mie;
      exp = (pend != '0) && ((c.priv == PRIV_LVL_U) || c.mstatus_mie);
      run_case(r_irq, c, exp, ref_winner(pend));
    end
    // Global enable off so wake lines raise no ack
    c = '{mie: 32'hFFFF_FFFF, mstatus_mie: 1'b0, mstatus_tw: 1'b0, priv: PRIV_LVL_M};
    enter_sleep(c, 1'b1, 0);
    wake_up(1'b0, 2);
    enter_sleep(c, 1'b1, 3);
    wake_up(1'b1, 1);
    c.priv = PRIV_LVL_U;
    c.mstatus_tw = 1'b1;
    enter_sleep(c, 1'b0, 0);
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: irq_ctrl_top.sv
// Top level of the machine interrupt and sleep controller, instantiate as the hart's IRQ block
`timescale 1ns/1ps
`include "irq_macros.svh"

module irq_ctrl_top
  import irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`IRQ_NUM-1:0] irq_i,
  input  irq_cfg_t            cfg_i,
  input  logic                wfi_i,
  input  logic                debug_req_i,
  input  logic                pipe_idle_i,
  output logic [`IRQ_NUM-1:0] mip_o,
  output irq_ack_t            ack_o,
  output logic                core_sleep_o,
  output logic                wake_o
);

  logic [`IRQ_NUM-1:0] pend_en;
  logic                timer_load;
  logic                timer_done;

  // --------------------
  // Interrupt path
  // --------------------

  // Only the enable word goes to the pending stage
  irq_pending u_pending (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .mie_i     (cfg_i.mie),
    .mip_o     (mip_o),
    .pend_en_o (pend_en)
  );

  irq_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .pend_en_i (pend_en),
    .cfg_i     (cfg_i),
    .ack_o     (ack_o)
  );

  // --------------------
  // Sleep path
  // --------------------

  sleep_timer u_timer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (timer_load),
    .done_o (timer_done)
  );

  wfi_fsm u_wfi (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wfi_i        (wfi_i),
    .cfg_i        (cfg_i),
    .pend_en_i    (pend_en),
    .debug_req_i  (debug_req_i),
    .pipe_idle_i  (pipe_idle_i),
    .timer_done_i (timer_done),
    .timer_load_o (timer_load),
    .core_sleep_o (core_sleep_o),
    .wake_o       (wake_o)
  );

endmodule

// File: irq_macros.svh
// Shared sizing and timing constants for the interrupt and sleep controller, include where needed
`ifndef IRQ_MACROS_SVH
`define IRQ_MACROS_SVH

// --------------------
// Interrupt lines
// --------------------

// Number of external interrupt lines into the hart
`define IRQ_NUM 32

// Implemented lines
// Platform lines 31..16 plus machine external, timer and software
`define IRQ_VALID_MASK 32'hFFFF_0888

// Width of an interrupt id on the acknowledge
`define IRQ_ID_W 5

// --------------------
// Sleep timing
// --------------------

// Minimum cycles from a retired WFI to core sleep
`define WFI_SLEEP_LATENCY 2

// Drain counter width, must hold WFI_SLEEP_LATENCY minus one
`define SLEEP_CNT_W 2

`endif

// File: irq_pending.sv
// Pending register for the external interrupt lines, feeds mip and the enabled-pending word
`timescale 1ns/1ps
`include "irq_macros.svh"

module irq_pending (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Raw lines from the platform
  input  logic [`IRQ_NUM-1:0] irq_i,

  // Per-line enables from mie
  input  logic [`IRQ_NUM-1:0] mie_i,

  // Registered pending word
  output logic [`IRQ_NUM-1:0] mip_o,

  // Pending and enabled
  output logic [`IRQ_NUM-1:0] pend_en_o
);

  // --------------------
  // Pending register
  // --------------------

  logic [`IRQ_NUM-1:0] irq_masked;
  logic [`IRQ_NUM-1:0] mip_q;

  // Reserved lines are dropped before the flop
  // so they can never show up in mip
  assign irq_masked = irq_i & `IRQ_VALID_MASK;

  // One cycle of latency from irq_i to mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_masked;
    end
  end

  assign mip_o = mip_q;

  // --------------------
  // Enabled pending
  // --------------------

  // Arbiter and sleep logic both see this word
  // Global enable and privilege are applied downstream
  assign pend_en_o = mip_q & mie_i;

endmodule

// File: irq_pkg.sv
// Types shared by the interrupt controller RTL and its testbench, import with irq_pkg::*
`include "irq_macros.svh"

package irq_pkg;

  // --------------------
  // Privilege
  // --------------------

  // RISC-V privilege encoding, only M and U are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // --------------------
  // Hart side config
  // --------------------

  // CSR fields that the hart drives into the controller
  typedef struct packed {
    logic [`IRQ_NUM-1:0] mie;
    logic                mstatus_mie;
    logic                mstatus_tw;
    priv_lvl_e           priv;
  } irq_cfg_t;

  // Acknowledge towards the hart
  // Valid is a single cycle strobe
  typedef struct packed {
    logic                 valid;
    logic [`IRQ_ID_W-1:0] id;
  } irq_ack_t;

  // Sleep controller states
  typedef enum logic [1:0] {
    RUN   = 2'b00,
    DRAIN = 2'b01,
    SLEEP = 2'b10
  } wfi_state_e;

endpackage

// File: project.f
+incdir+.
irq_pkg.sv
irq_pending.sv
irq_arbiter.sv
sleep_timer.sv
wfi_fsm.sv
irq_ctrl_top.sv
irq_ctrl_props.sv
irq_ctrl_tb.sv

// File: sleep_timer.sv
// Drain delay counter for WFI, loaded by the sleep FSM and reporting when the delay has elapsed
`timescale 1ns/1ps
`include "irq_macros.svh"

module sleep_timer (
  input  logic clk_i,
  input  logic rst_ni,

  // Start of a new drain period
  input  logic load_i,

  // Counter reached zero
  output logic done_o
);

  // --------------------
  // Counter
  // --------------------

  localparam logic [`SLEEP_CNT_W-1:0] LOAD_VAL = `SLEEP_CNT_W'(`WFI_SLEEP_LATENCY - 1);

  logic [`SLEEP_CNT_W-1:0] cnt_q;
  logic                    cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  // Load wins over counting
  // Holds at zero until the next load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= LOAD_VAL;
    end else if (!cnt_zero) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // High out of reset too
  // the FSM only looks at it while draining
  assign done_o = cnt_zero;

endmodule

// File: wfi_fsm.sv
// WFI sleep state machine, qualifies WFI, waits out the drain and idle pipe, then sleeps until woken
`timescale 1ns/1ps
`include "irq_macros.svh"

module wfi_fsm
  import irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,

  // Retired WFI strobe
  input  logic                wfi_i,
  input  irq_cfg_t            cfg_i,

  // Wake causes
  input  logic [`IRQ_NUM-1:0] pend_en_i,
  input  logic                debug_req_i,

  // Pipeline has nothing in flight
  input  logic                pipe_idle_i,

  // Drain timer handshake
  input  logic                timer_done_i,
  output logic                timer_load_o,

  output logic                core_sleep_o,
  output logic                wake_o
);

  wfi_state_e state_q;
  wfi_state_e state_d;
  logic       wfi_ok;
  logic       wake_cause;
  logic       wake_q;

  // --------------------
  // Qualifiers
  // --------------------

  // U-mode with TW set makes WFI trap instead of sleep
  assign wfi_ok = wfi_i && !((cfg_i.priv == PRIV_LVL_U) && cfg_i.mstatus_tw);

  // Wake ignores mstatus.mie and privilege
  assign wake_cause = (|pend_en_i) || debug_req_i;

  // Timer restarts on every accepted WFI
  assign timer_load_o = (state_q == RUN) && wfi_ok;

  // --------------------
  // Next state
  // --------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (wfi_ok) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // A wake cause aborts the drain
        if (wake_cause) begin
          state_d = RUN;
        end else if (timer_done_i && pipe_idle_i) begin
          state_d = SLEEP;
        end
      end
      SLEEP: begin
        if (wake_cause) begin
          state_d = RUN;
        end
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN;
      wake_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Pulse on the edge that returns to RUN
      wake_q  <= (state_q != RUN) && wake_cause;
    end
  end

  assign core_sleep_o = (state_q == SLEEP);
  assign wake_o       = wake_q;

endmodule
